//--- flist.f
source/mapperPkg.sv
source/mapperRegs.sv
source/mapperTranslate.sv
source/sccWaveRam.sv
source/megaMapperTop.sv
tests/tbMegaMapperChecks.sv
tests/tbMegaMapper.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the mapper testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tbMegaMapper

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" -o simv \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR"/simv > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG_FILE"; then
    exit 1
fi
exit 0

//--- source/mapperPkg.sv
package mapperPkg;

    // One CPU cycle as seen by the cartridge slot
    typedef struct packed {
        logic [15:0] addr;                  // Z80 address
        logic [7:0]  data;                  // Write data
        logic        wr;                    // Write level, low = read
        logic        mreq;                  // Memory request level
        logic        req;                   // One-cycle request strobe
    } cpuBus_t;

    // Bit 0 = ASCII style, bit 1 = 16K pages
    typedef enum logic [1:0] {
        modeScc   = 2'b00,                  // Konami SCC / MegaROM
        modeAsc8  = 2'b01,
        modeAsc16 = 2'b11
    } mapperMode_e;

    // ASCII-16K view of a bank-select byte
    typedef struct packed {
        logic       hi;                     // Carried into bank bit 7
        logic       ramSel;                 // SRAM select on some boards
        logic [5:0] page;                   // 16K page number
    } asc16Word_t;

    // Same data byte, two decodings
    typedef union packed {
        logic [7:0] bank8k;                 // Plain 8K bank number
        asc16Word_t asc16;
    } ascBankWord_u;

    typedef struct packed {
        logic [7:0] bank0;                  // 4000-5FFFh
        logic [7:0] bank1;                  // 6000-7FFFh
        logic [7:0] bank2;                  // 8000-9FFFh
        logic [7:0] bank3;                  // A000-BFFFh
    } bankSet_t;

    // Access class of the current CPU cycle
    typedef enum logic [1:0] {
        selBankReg = 2'b00,
        selMemory  = 2'b01,
        selWave    = 2'b10
    } sccSel_e;

    localparam int ROM_ADDR_W_DEFAULT = 21; // 2 MB external space
    localparam int MAX_ROM_ADDR_W     = 24;
    localparam int PAGE_OFS_W         = 13; // 8K page offset

    // Address [15:13] of the four 8K pages
    localparam logic [2:0] PAGE_4000 = 3'b010;
    localparam logic [2:0] PAGE_6000 = 3'b011;
    localparam logic [2:0] PAGE_8000 = 3'b100;
    localparam logic [2:0] PAGE_A000 = 3'b101;

    // Address [15:11] of the SCC bank registers and wave windows
    localparam logic [4:0] SCC_BANK0_REG = 5'b01010; // 5000-57FFh
    localparam logic [4:0] SCC_BANK1_REG = 5'b01110; // 7000-77FFh
    localparam logic [4:0] SCC_BANK2_REG = 5'b10010; // 9000-97FFh
    localparam logic [4:0] SCC_BANK3_REG = 5'b10110; // B000-B7FFh
    localparam logic [4:0] SCC_WAVE_A    = 5'b10011; // 9800-9FFFh
    localparam logic [4:0] SCC_WAVE_B    = 5'b10111; // B800-BFFFh, SCC+ layout
    localparam logic [5:0] WAVE_BANK_ID  = 6'h3F;    // Bank 2 value that opens the SCC

    // Address [15:12] of the ASCII bank registers
    localparam logic [3:0] ASC_REG_LO = 4'b0110;     // 6000-6FFFh
    localparam logic [3:0] ASC_REG_HI = 4'b0111;     // 7000-7FFFh

endpackage

//--- source/mapperRegs.sv
`timescale 1ns/100ps

module mapperRegs (
    input  logic                   cpu_bus,
    input  logic                   arstN,
    input  mapperPkg::cpuBus_t     cpuBus,
    input  mapperPkg::mapperMode_e mapperMode,
    output mapperPkg::bankSet_t    banks,
    output mapperPkg::sccSel_e     accessSel,
    output logic                   waveWr,
    output logic                   waveRd,
    output logic [6:0]             waveAddr
);
    import mapperPkg::*;

    logic         ascStyle;                 // ASCII 8K or 16K
    logic         page16k;                  // ASCII 16K pairs
    logic [7:0]   modeA;                    // SCC mode register at 7FFEh
    logic [7:0]   modeB;                    // SCC mode register at BFFEh
    logic         decWaveA;
    logic         decWaveB;
    logic         dec1FFE;                  // xFFE/xFFF inside an 8K page
    logic [2:0]   page;
    logic         rd;
    logic         regWrite;
    ascBankWord_u ascWord;

    assign ascStyle = mapperMode[0];
    assign page16k  = mapperMode[1];
    assign page     = cpuBus.addr[15:13];
    assign rd       = ~cpuBus.wr;
    assign ascWord.bank8k = cpuBus.data;    // Decoded both ways below

    assign decWaveA = (cpuBus.addr[15:11] == SCC_WAVE_A) && ~modeB[5]
                      && (banks.bank2[5:0] == WAVE_BANK_ID);
    assign decWaveB = (cpuBus.addr[15:11] == SCC_WAVE_B) && modeB[5] && banks.bank3[7];
    assign dec1FFE  = &cpuBus.addr[12:1];

    // Access class, wave first, then memory, rest hits registers
    always_comb begin
        if (~cpuBus.addr[8] && ~modeB[4] && ~ascStyle && (decWaveA || decWaveB)) begin
            accessSel = selWave;
        end else if (
            (ascStyle && rd && (page == PAGE_4000 || page == PAGE_6000)) ||   // ASCII ROM read
            (ascStyle && rd && (page == PAGE_8000 || page == PAGE_A000)) ||
            (ascStyle && page == PAGE_4000 && banks.bank0[7])            ||   // ASCII SRAM
            (ascStyle && page == PAGE_8000 && banks.bank2[7])            ||
            (ascStyle && page == PAGE_A000 && banks.bank3[7])            ||
            (page == PAGE_4000 && ~modeA[6] && rd)                       ||   // SCC ROM read
            (page == PAGE_6000 && rd)                                    ||
            (page == PAGE_8000 && ~decWaveA && rd)                       ||
            (page == PAGE_A000 && ~modeA[6] && ~decWaveB && rd)          ||
            (page == PAGE_4000 && modeA[4])                              ||   // ESCC-RAM
            (page == PAGE_6000 && modeA[4] && ~dec1FFE)                  ||
            (page == PAGE_4000 && modeB[4])                              ||   // SNATCHER RAM
            (page == PAGE_6000 && modeB[4])                              ||
            (page == PAGE_8000 && modeB[4])                              ||
            (page == PAGE_A000 && modeB[4] && ~dec1FFE)
        ) begin
            accessSel = selMemory;
        end else begin
            accessSel = selBankReg;
        end
    end

    assign regWrite = cpuBus.req && cpuBus.mreq && cpuBus.wr && (accessSel == selBankReg);

    always_ff @(posedge cpu_bus or negedge arstN) begin
        if (!arstN) begin
            banks.bank0 <= 8'h00;           // Linear layout after reset
            banks.bank1 <= 8'h01;
            banks.bank2 <= 8'h02;
            banks.bank3 <= 8'h03;
            modeA       <= 8'h00;
            modeB       <= 8'h00;
        end else if (regWrite) begin
            if (!ascStyle) begin
                // Konami SCC bank registers, locked while SNATCHER RAM is on
                if (~modeB[4]) begin
                    case (cpuBus.addr[15:11])
                        SCC_BANK0_REG: begin
                            if (~modeA[6] && ~modeA[4]) begin
                                banks.bank0 <= cpuBus.data;
                            end
                        end
                        SCC_BANK1_REG: begin
                            if (~modeA[6] && ~modeA[4]) begin
                                banks.bank1 <= cpuBus.data;
                            end
                        end
                        SCC_BANK2_REG: banks.bank2 <= cpuBus.data;  // Never locked
                        SCC_BANK3_REG: begin
                            if (~modeA[6] && ~modeA[4]) begin
                                banks.bank3 <= cpuBus.data;
                            end
                        end
                        default: ;
                    endcase
                end
                // Mode registers at 7FFEh and BFFEh
                if (dec1FFE) begin
                    if (page == PAGE_6000 && modeB[5:4] == 2'b00) begin
                        modeA <= cpuBus.data;
                    end
                    if (page == PAGE_A000 && ~modeA[6] && ~modeA[4]) begin
                        modeB <= cpuBus.data;
                    end
                end
            end else if (page16k) begin
                // ASCII 16K, one write sets an 8K pair
                if (cpuBus.addr[15:12] == ASC_REG_LO && ~cpuBus.addr[11]) begin
                    banks.bank0 <= {ascWord.asc16.hi, ascWord.asc16.page, 1'b0};
                    banks.bank1 <= {ascWord.asc16.hi, ascWord.asc16.page, 1'b1};
                end
                if (cpuBus.addr[15:12] == ASC_REG_HI && ~cpuBus.addr[11]) begin
                    banks.bank2 <= {ascWord.asc16.hi, ascWord.asc16.page, 1'b0};
                    banks.bank3 <= {ascWord.asc16.hi, ascWord.asc16.page, 1'b1};
                end
            end else begin
                // ASCII 8K, addr[11] picks the odd bank
                if (cpuBus.addr[15:12] == ASC_REG_LO) begin
                    if (cpuBus.addr[11]) begin
                        banks.bank1 <= ascWord.bank8k;  // 6800h
                    end else begin
                        banks.bank0 <= ascWord.bank8k;  // 6000h
                    end
                end
                if (cpuBus.addr[15:12] == ASC_REG_HI) begin
                    if (cpuBus.addr[11]) begin
                        banks.bank3 <= ascWord.bank8k;  // 7800h
                    end else begin
                        banks.bank2 <= ascWord.bank8k;  // 7000h
                    end
                end
            end
        end
    end

    // Waveform port strobes
    assign waveWr   = cpuBus.req && cpuBus.mreq && cpuBus.wr && (accessSel == selWave);
    assign waveRd   = cpuBus.req && cpuBus.mreq && rd && (accessSel == selWave);
    assign waveAddr = cpuBus.addr[6:0];     // 128-byte window, upper bits alias

endmodule

//--- source/mapperTranslate.sv
`timescale 1ns/100ps

module mapperTranslate #(
    parameter int ROM_ADDR_W = mapperPkg::ROM_ADDR_W_DEFAULT
) (
    input  mapperPkg::cpuBus_t  cpuBus,
    input  mapperPkg::bankSet_t banks,
    input  mapperPkg::sccSel_e  accessSel,
    output logic [ROM_ADDR_W-1:0] memAddr,
    output logic                  memRd,
    output logic                  memWr
);
    import mapperPkg::*;

    localparam int LIN_W = 8 + PAGE_OFS_W;  // Bank byte and page offset

    logic [7:0]                bankSel;
    logic                      inWindow;
    logic                      memCycle;
    logic [MAX_ROM_ADDR_W-1:0] linAddr;

    // Page select from address [15:13]
    always_comb begin
        case (cpuBus.addr[15:13])
            PAGE_4000: bankSel = banks.bank0;
            PAGE_6000: bankSel = banks.bank1;
            PAGE_8000: bankSel = banks.bank2;
            PAGE_A000: bankSel = banks.bank3;
            default:   bankSel = 8'h00;     // Outside the cartridge window
        endcase
    end

    assign inWindow = (cpuBus.addr[15:14] == 2'b01) || (cpuBus.addr[15:14] == 2'b10);

    // Zero-padded to the widest supported memory
    assign linAddr = {{(MAX_ROM_ADDR_W - LIN_W){1'b0}}, bankSel, cpuBus.addr[PAGE_OFS_W-1:0]};
    assign memAddr = linAddr[ROM_ADDR_W-1:0];  // High bank bits drop on small parts

    assign memCycle = cpuBus.req && cpuBus.mreq && inWindow && (accessSel == selMemory);
    assign memRd    = memCycle && ~cpuBus.wr;
    assign memWr    = memCycle && cpuBus.wr;

endmodule

//--- source/megaMapperTop.sv
`timescale 1ns/100ps

module megaMapperTop #(
    parameter int ROM_ADDR_W = mapperPkg::ROM_ADDR_W_DEFAULT
) (
    input  logic                   cpu_bus,
    input  logic                   arstN,
    input  mapperPkg::cpuBus_t     cpuBus,
    input  mapperPkg::mapperMode_e mapperMode,
    output logic [ROM_ADDR_W-1:0]  memAddr,
    output logic                   memRd,
    output logic                   memWr,
    output logic [7:0]             readData
);
    import mapperPkg::*;

    bankSet_t   banks;                      // Current page mapping
    sccSel_e    accessSel;                  // Class of this cycle
    logic       waveWr;
    logic       waveRd;
    logic [6:0] waveAddr;

    mapperRegs uRegs (
        .cpu_bus    (cpu_bus),
        .arstN      (arstN),
        .cpuBus     (cpuBus),
        .mapperMode (mapperMode),
        .banks      (banks),
        .accessSel  (accessSel),
        .waveWr     (waveWr),
        .waveRd     (waveRd),
        .waveAddr   (waveAddr)
    );

    mapperTranslate #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) uTranslate (
        .cpuBus    (cpuBus),
        .banks     (banks),
        .accessSel (accessSel),
        .memAddr   (memAddr),
        .memRd     (memRd),
        .memWr     (memWr)
    );

    sccWaveRam uWaveRam (
        .cpu_bus   (cpu_bus),
        .waveWr    (waveWr),
        .waveRd    (waveRd),
        .waveAddr  (waveAddr),
        .writeData (cpuBus.data),           // CPU write byte
        .waveData  (readData)
    );

endmodule

//--- source/sccWaveRam.sv
`timescale 1ns/100ps

module sccWaveRam (
    input  logic       cpu_bus,
    input  logic       waveWr,
    input  logic       waveRd,
    input  logic [6:0] waveAddr,
    input  logic [7:0] writeData,
    output logic [7:0] waveData
);

    // Four 32-sample channels of 8-bit signed samples
    logic [7:0] waveMem [128];

    always_ff @(posedge cpu_bus) begin
        if (waveWr) begin
            waveMem[waveAddr] <= writeData;     // Stored at the strobe edge
        end
    end

    // Read port holds its value between reads
    always_ff @(posedge cpu_bus) begin
        if (waveRd) begin
            waveData <= waveMem[waveAddr];      // Valid one cycle after strobe
        end
    end

endmodule

//--- tests/tbMegaMapper.sv
`timescale 1ns/100ps

module tbMegaMapper;
    import mapperPkg::*;

    localparam int ROM_ADDR_W = 21;             // 2 MB cartridge space

    logic                  cpu_bus;
    logic                  arstN;
    cpuBus_t               cpuBus;
    mapperMode_e           mapperMode;
    logic [ROM_ADDR_W-1:0] memAddr;
    logic                  memRd;
    logic                  memWr;
    logic [7:0]            readData;
    int                    errorCount;          // From the checker
    int                    timeoutCount;
    logic [31:0]           rngState;

    initial begin
        cpu_bus = 1'b0;
        forever #2 cpu_bus = ~cpu_bus;          // 4 ns period
    end

    megaMapperTop #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) dut_i (
        .cpu_bus    (cpu_bus),
        .arstN      (arstN),
        .cpuBus     (cpuBus),
        .mapperMode (mapperMode),
        .memAddr    (memAddr),
        .memRd      (memRd),
        .memWr      (memWr),
        .readData   (readData)
    );

    mapperChecker #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) checkI (
        .cpu_bus    (cpu_bus),
        .arstN      (arstN),
        .cpuBus     (cpuBus),
        .mapperMode (mapperMode),
        .memAddr    (memAddr),
        .memRd      (memRd),
        .memWr      (memWr),
        .readData   (readData),
        .errorCount (errorCount)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One strobed CPU cycle, then an idle cycle
    task automatic busAccess(input logic [15:0] addr, input logic [7:0] data,
                             input logic write);
        @(posedge cpu_bus);
        #1;
        cpuBus.addr = addr;
        cpuBus.data = data;
        cpuBus.wr   = write;
        cpuBus.mreq = 1'b1;
        cpuBus.req  = 1'b1;
        @(posedge cpu_bus);
        #1;
        cpuBus.req  = 1'b0;
        cpuBus.mreq = 1'b0;
        cpuBus.wr   = 1'b0;
    endtask

    task automatic setMode(input mapperMode_e mode);
        @(posedge cpu_bus);
        #1 mapperMode = mode;
    endtask

    task automatic waitStrobesLow(input int limit);
        int n;
        n = 0;
        while ((memRd !== 1'b0 || memWr !== 1'b0) && n < limit) begin
            @(posedge cpu_bus);
            n++;
        end
        if (memRd !== 1'b0 || memWr !== 1'b0) begin
            timeoutCount++;
            $display("Timeout: memory strobes not low %0d cycles after reset", limit);
        end
    endtask

    initial begin
        logic [15:0] ofs;
        cpuBus       = '0;
        mapperMode   = modeScc;
        arstN        = 1'b0;
        timeoutCount = 0;
        rngState     = 32'h0d34_4fea;
        repeat (5) @(posedge cpu_bus);
        #1 arstN = 1'b1;
        waitStrobesLow(20);

        // Reset layout, one read per 8K page
        for (int n = 0; n < 4; n++) begin
            rngState = xorshift32(rngState);
            ofs      = {3'b000, rngState[12:0]};
            busAccess(16'h4000 + 16'(n) * 16'h2000 + ofs, 8'h00, 1'b0);
        end

        // SCC bank registers, each followed by a read of its page
        for (int r = 0; r < 3; r++) begin
            for (int n = 0; n < 4; n++) begin
                rngState = xorshift32(rngState);
                ofs      = {3'b000, rngState[28:16]};
                busAccess(16'h5000 + 16'(n) * 16'h2000, rngState[7:0], 1'b1);
                busAccess(16'h4000 + 16'(n) * 16'h2000 + ofs, 8'h00, 1'b0);
            end
        end

        // Open the SCC window, fill it, read it back
        busAccess(16'h9000, 8'h3F, 1'b1);
        for (int a = 0; a < 128; a++) begin
            rngState = xorshift32(rngState);
            busAccess(16'h9800 + 16'(a), rngState[7:0], 1'b1);
        end
        for (int a = 0; a < 128; a++) begin
            busAccess(16'h9800 + 16'(a), 8'h00, 1'b0);
        end

        setMode(modeAsc8);
        for (int n = 0; n < 4; n++) begin
            rngState = xorshift32(rngState);
            ofs      = {3'b000, rngState[28:16]};
            busAccess(16'h6000 + 16'(n) * 16'h0800, rngState[7:0], 1'b1);
            busAccess(16'h4000 + 16'(n) * 16'h2000 + ofs, 8'h00, 1'b0);
        end

        setMode(modeAsc16);
        for (int n = 0; n < 2; n++) begin
            rngState = xorshift32(rngState);
            ofs      = {3'b000, rngState[28:16]};
            busAccess(16'h6000 + 16'(n) * 16'h1000, rngState[7:0], 1'b1);
            busAccess(16'h4000 + 16'(n) * 16'h4000 + ofs, 8'h00, 1'b0);  // Even 8K half
            busAccess(16'h6000 + 16'(n) * 16'h4000 + ofs, 8'h00, 1'b0);  // Odd 8K half
        end

        // ESCC-RAM locks bank 0 and opens 4000h for writes
        setMode(modeScc);
        busAccess(16'h7FFE, 8'h10, 1'b1);
        rngState = xorshift32(rngState);
        ofs      = {3'b000, rngState[28:16]};
        busAccess(16'h5000, rngState[7:0], 1'b1);
        busAccess(16'h4000 + ofs, 8'h00, 1'b0);
        busAccess(16'h4000 + ofs, rngState[15:8], 1'b1);

        // Outside the cartridge window, both directions
        for (int n = 0; n < 16; n++) begin
            rngState = xorshift32(rngState);
            busAccess({((n % 2) == 1) ? 2'b11 : 2'b00, rngState[13:0]}, rngState[23:16],
                      rngState[31]);
        end

        repeat (2) @(posedge cpu_bus);
        $display("Check errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tests/tbMegaMapperChecks.sv
`timescale 1ns/100ps

module mapperChecker #(
    parameter int ROM_ADDR_W = mapperPkg::ROM_ADDR_W_DEFAULT
) (
    input  logic                   cpu_bus,
    input  logic                   arstN,
    input  mapperPkg::cpuBus_t     cpuBus,
    input  mapperPkg::mapperMode_e mapperMode,
    input  logic [ROM_ADDR_W-1:0]  memAddr,
    input  logic                   memRd,
    input  logic                   memWr,
    input  logic [7:0]             readData,
    output int                     errorCount
);
    import mapperPkg::*;

    logic [7:0]            bankModel [4];       // Expected 8K bank per page
    logic [7:0]            modeA;               // Expected 7FFEh register
    logic [7:0]            modeB;               // Expected BFFEh register
    logic [7:0]            waveModel [128];
    logic [7:0]            waveExpect;          // Byte due on readData
    logic                  waveCheck;           // Read strobe seen last edge
    logic                  sccMode;
    logic                  cycle;
    logic                  inWindow;
    logic                  xFFE;
    logic                  waveHit;
    logic                  memWrClass;
    logic                  expRd;
    logic                  expWr;
    logic [2:0]            page;
    logic [1:0]            slot;
    logic [31:0]           linAddr;
    logic [ROM_ADDR_W-1:0] expAddr;
    ascBankWord_u          dataWord;

    initial errorCount = 0;

    assign sccMode         = (mapperMode == modeScc);
    assign cycle           = cpuBus.req && cpuBus.mreq;
    assign page            = cpuBus.addr[15:13];
    assign slot            = 2'(page - 3'd2);   // 4000h page is bank 0
    assign inWindow        = (cpuBus.addr >= 16'h4000) && (cpuBus.addr <= 16'hBFFF);
    assign xFFE            = &cpuBus.addr[12:1];
    assign dataWord.bank8k = cpuBus.data;
    assign waveHit = sccMode && (cpuBus.addr >= 16'h9800) && (cpuBus.addr <= 16'h9FFF)
                     && ~cpuBus.addr[8] && (bankModel[2][5:0] == 6'h3F)
                     && ~modeB[4] && ~modeB[5];

    // Writes that reach external RAM
    assign memWrClass =
        (~sccMode && ((page == 3'b010 && bankModel[0][7]) ||      // ASCII SRAM
                      (page == 3'b100 && bankModel[2][7]) ||
                      (page == 3'b101 && bankModel[3][7]))) ||
        (page == 3'b010 && (modeA[4] || modeB[4]))            ||  // ESCC-RAM, SNATCHER
        (page == 3'b011 && ((modeA[4] && ~xFFE) || modeB[4])) ||
        (page == 3'b100 && modeB[4])                          ||
        (page == 3'b101 && modeB[4] && ~xFFE);

    assign expRd   = cycle && ~cpuBus.wr && inWindow && ~waveHit;
    assign expWr   = cycle && cpuBus.wr && inWindow && ~waveHit && memWrClass;
    assign linAddr = {11'b0, bankModel[slot], cpuBus.addr[12:0]};
    assign expAddr = linAddr[ROM_ADDR_W-1:0];

    always_ff @(posedge cpu_bus or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 4; i++) begin
                bankModel[i] <= 8'(i);                  // Linear 0..3
            end
            modeA     <= 8'h00;
            modeB     <= 8'h00;
            waveCheck <= 1'b0;
        end else begin
            waveCheck <= cycle && ~cpuBus.wr && waveHit;
            if (cycle && cpuBus.wr && ~waveHit && ~memWrClass) begin
                case (mapperMode)
                    modeScc: begin
                        if (~modeB[4]) begin
                            case (cpuBus.addr[15:11])
                                5'b01010: if (~modeA[6] && ~modeA[4]) bankModel[0] <= cpuBus.data;
                                5'b01110: if (~modeA[6] && ~modeA[4]) bankModel[1] <= cpuBus.data;
                                5'b10010: bankModel[2] <= cpuBus.data;
                                5'b10110: if (~modeA[6] && ~modeA[4]) bankModel[3] <= cpuBus.data;
                                default: ;
                            endcase
                        end
                        if (xFFE && page == 3'b011 && modeB[5:4] == 2'b00) begin
                            modeA <= cpuBus.data;
                        end
                        if (xFFE && page == 3'b101 && ~modeA[6] && ~modeA[4]) begin
                            modeB <= cpuBus.data;
                        end
                    end
                    modeAsc8: begin
                        case (cpuBus.addr[15:11])
                            5'b01100: bankModel[0] <= dataWord.bank8k;   // 6000h
                            5'b01101: bankModel[1] <= dataWord.bank8k;   // 6800h
                            5'b01110: bankModel[2] <= dataWord.bank8k;   // 7000h
                            5'b01111: bankModel[3] <= dataWord.bank8k;   // 7800h
                            default: ;
                        endcase
                    end
                    modeAsc16: begin
                        // Page p covers 8K banks 2p and 2p+1
                        if (cpuBus.addr[15:11] == 5'b01100) begin
                            bankModel[0] <= {dataWord.asc16.hi, dataWord.asc16.page, 1'b0};
                            bankModel[1] <= {dataWord.asc16.hi, dataWord.asc16.page, 1'b1};
                        end
                        if (cpuBus.addr[15:11] == 5'b01110) begin
                            bankModel[2] <= {dataWord.asc16.hi, dataWord.asc16.page, 1'b0};
                            bankModel[3] <= {dataWord.asc16.hi, dataWord.asc16.page, 1'b1};
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Waveform contents and the byte a read should return
    always_ff @(posedge cpu_bus) begin
        if (cycle && cpuBus.wr && waveHit) begin
            waveModel[cpuBus.addr[6:0]] <= cpuBus.data;
        end
        if (cycle && ~cpuBus.wr && waveHit) begin
            waveExpect <= waveModel[cpuBus.addr[6:0]];
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errorCount++;
        $display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, exp);
    endtask

    // Sampled mid-cycle, inputs and outputs settled
    rdStrobe: assert property (@(negedge cpu_bus) disable iff (!arstN) memRd == expRd)
        else reportMismatch("memRd", 32'(memRd), 32'(expRd));
    wrStrobe: assert property (@(negedge cpu_bus) disable iff (!arstN) memWr == expWr)
        else reportMismatch("memWr", 32'(memWr), 32'(expWr));
    addrMap: assert property (@(negedge cpu_bus) disable iff (!arstN)
                              (expRd || expWr) |-> (memAddr == expAddr))
        else reportMismatch("memAddr", 32'(memAddr), 32'(expAddr));
    waveRead: assert property (@(negedge cpu_bus) disable iff (!arstN)
                               waveCheck |-> (readData == waveExpect))
        else reportMismatch("readData", 32'(readData), 32'(waveExpect));

endmodule
